// ==== common/icache_macros.svh ====
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// widths of the tag, index and offset address fields
`define ICACHE_INDEX_W   6
`define ICACHE_OFFSET_W  6
`define ICACHE_TAG_W     20

// line and fetch sizes
`define ICACHE_LINE_W    512
`define ICACHE_FETCH_W   64
`define ICACHE_PAIRS     8

// cache operation codes
`define ICACHE_OP_IDX_INV  2'b01
`define ICACHE_OP_HIT_INV  2'b10

// returned for both slots of a faulting fetch
`define ICACHE_NOP  32'h0340_0000

`endif

// ==== common/icache_pkg.sv ====
`default_nettype none

`include "icache_macros.svh"

package icache_pkg;

    // one cache line seen either as a flat word as the arrays and memory hold it
    // or as instruction pairs with the lowest address in pair 0
    typedef union packed {
        logic [`ICACHE_LINE_W-1:0]                    flat;
        logic [`ICACHE_PAIRS-1:0][`ICACHE_FETCH_W-1:0] pair;
    } icache_line_u;

endpackage

`default_nettype wire

// ==== filelist.f ====
+incdir+common
common/icache_pkg.sv
icache/icache_way.sv
icache/icache_ctrl.sv
src/icache_top.sv
verif/tb_icache.sv

// ==== icache/icache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "icache_macros.svh"

module icache_ctrl import icache_pkg::*; (
    input  wire                        clk,
    input  wire                        rstn,
    // fetch side
    input  wire                        i_req,
    input  wire [31:0]                 i_addr,
    output logic                       o_ready,
    output logic                       o_resp_valid,
    output logic [31:0]                o_resp_pc,
    output logic [`ICACHE_FETCH_W-1:0] o_resp_data,
    output logic                       o_resp_adef,
    // cache operation side
    input  wire                        i_cacop,
    input  wire [1:0]                  i_cacop_code,
    output logic                       o_cacop_done,
    // memory side
    output logic                       o_mem_req,
    output logic [31:0]                o_mem_addr,
    input  wire                        i_mem_valid,
    input  wire [`ICACHE_LINE_W-1:0]   i_mem_line,
    // ways
    output logic [`ICACHE_INDEX_W-1:0] o_rd_index,
    output logic [`ICACHE_TAG_W-1:0]   o_cmp_tag,
    output logic [`ICACHE_INDEX_W-1:0] o_wr_index,
    output logic [`ICACHE_TAG_W-1:0]   o_wr_tag,
    output icache_line_u               o_wr_line,
    output logic                       o_wr_en0,
    output logic                       o_wr_en1,
    output logic                       o_inv_en0,
    output logic                       o_inv_en1,
    input  wire                        i_hit0,
    input  wire                        i_hit1,
    input  wire icache_line_u          i_line0,
    input  wire icache_line_u          i_line1
);

    localparam logic [2:0] s_idle   = 3'd0;
    localparam logic [2:0] s_lookup = 3'd1;
    localparam logic [2:0] s_miss   = 3'd2;
    localparam logic [2:0] s_refill = 3'd3;
    localparam logic [2:0] s_cacop  = 3'd4;

    localparam int idx_lo = `ICACHE_OFFSET_W;
    localparam int tag_lo = `ICACHE_OFFSET_W + `ICACHE_INDEX_W;

    logic [2:0]                 state;
    logic [2:0]                 state_nxt;
    logic [2:0]                 accept_state;
    logic [31:0]                req_addr;
    logic [1:0]                 req_code;
    icache_line_u               ret_buf;
    logic [(1 << `ICACHE_INDEX_W)-1:0] lru;
    logic [`ICACHE_INDEX_W-1:0] req_index;
    logic                       accept_req;
    logic                       accept_op;
    logic                       adef;
    logic                       cache_hit;
    logic                       lookup_done;
    logic                       victim;
    icache_line_u               sel_line;

    assign req_index   = req_addr[tag_lo-1:idx_lo];
    assign adef        = |req_addr[1:0];
    assign cache_hit   = i_hit0 || i_hit1;
    // lru bit names the way to replace
    assign victim      = lru[req_index];
    // a fault or a hit finishes in the lookup cycle
    assign lookup_done = (state == s_lookup) && (adef || cache_hit);

    assign o_ready    = (state == s_idle) || lookup_done;
    assign accept_req = o_ready && i_req;
    assign accept_op  = o_ready && i_cacop;

    assign accept_state = accept_op ? s_cacop : (accept_req ? s_lookup : s_idle);

    always_comb begin
        state_nxt = state;
        case (state)
            s_idle:   state_nxt = accept_state;
            s_lookup: state_nxt = lookup_done ? accept_state : s_miss;
            s_miss:   state_nxt = i_mem_valid ? s_refill : s_miss;
            s_refill: state_nxt = s_idle;
            s_cacop:  state_nxt = s_idle;
            default:  state_nxt = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= s_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (accept_req || accept_op) begin
            req_addr <= i_addr;
            req_code <= i_cacop_code;
        end
    end

    // return buffer takes the whole line in one strobe
    always_ff @(posedge clk) begin
        if (i_mem_valid) begin
            ret_buf.flat <= i_mem_line;
        end
    end

    // point away from the way just used
    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru <= '0;
        end else if ((state == s_lookup) && !adef && cache_hit) begin
            lru[req_index] <= i_hit0;
        end else if (state == s_refill) begin
            lru[req_index] <= !victim;
        end
    end

    // one pulse on the first miss cycle
    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_mem_req <= 1'b0;
        end else begin
            o_mem_req <= (state == s_lookup) && !lookup_done;
        end
    end

    assign o_mem_addr = {req_addr[31:idx_lo], {`ICACHE_OFFSET_W{1'b0}}};

    // ways read at the incoming address and compare against the buffered tag
    assign o_rd_index = i_addr[tag_lo-1:idx_lo];
    assign o_cmp_tag  = req_addr[31:tag_lo];
    assign o_wr_index = req_index;
    assign o_wr_tag   = req_addr[31:tag_lo];
    assign o_wr_line  = ret_buf;
    assign o_wr_en0   = (state == s_refill) && !victim;
    assign o_wr_en1   = (state == s_refill) && victim;

    always_comb begin
        o_inv_en0 = 1'b0;
        o_inv_en1 = 1'b0;
        if (state == s_cacop) begin
            case (req_code)
                `ICACHE_OP_IDX_INV: begin
                    o_inv_en0 = !req_addr[0];
                    o_inv_en1 = req_addr[0];
                end
                // both miss leaves the set alone
                `ICACHE_OP_HIT_INV: begin
                    o_inv_en0 = i_hit0;
                    o_inv_en1 = i_hit1;
                end
                default: ;
            endcase
        end
    end

    assign o_cacop_done = (state == s_cacop);

    // refill answers from the return buffer
    assign sel_line = (state == s_refill) ? ret_buf : (i_hit1 ? i_line1 : i_line0);

    assign o_resp_valid = lookup_done || (state == s_refill);
    assign o_resp_pc    = req_addr;
    assign o_resp_adef  = (state == s_lookup) && adef;
    assign o_resp_data  = adef ? {`ICACHE_NOP, `ICACHE_NOP}
                               : sel_line.pair[req_addr[`ICACHE_OFFSET_W-1:3]];

    a_req_when_ready: assert property (@(posedge clk) disable iff (!rstn)
        i_req |-> o_ready);

    a_mem_valid_in_miss: assert property (@(posedge clk) disable iff (!rstn)
        i_mem_valid |-> (state == s_miss));

    // a line lives in at most one way
    a_one_way_hit: assert property (@(posedge clk) disable iff (!rstn)
        !(i_hit0 && i_hit1));

endmodule

`default_nettype wire

// ==== icache/icache_way.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "icache_macros.svh"

module icache_way import icache_pkg::*; (
    input  wire                        clk,
    input  wire                        rstn,
    // read port
    input  wire [`ICACHE_INDEX_W-1:0]  i_rd_index,
    input  wire [`ICACHE_TAG_W-1:0]    i_cmp_tag,
    // write and invalidate port
    input  wire                        i_wr_en,
    input  wire [`ICACHE_INDEX_W-1:0]  i_wr_index,
    input  wire [`ICACHE_TAG_W-1:0]    i_wr_tag,
    input  wire icache_line_u          i_wr_line,
    input  wire                        i_inv_en,
    // lookup result one cycle after the read index
    output logic                       o_hit,
    output icache_line_u               o_line
);

    localparam int sets = 1 << `ICACHE_INDEX_W;

    logic [sets-1:0]          valid;
    logic [`ICACHE_TAG_W-1:0] tag_mem [sets];
    icache_line_u             data_mem [sets];

    logic                     valid_q;
    logic [`ICACHE_TAG_W-1:0] tag_q;

    // a refill sets the valid bit and an invalidate clears it
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '0;
        end else if (i_wr_en) begin
            valid[i_wr_index] <= 1'b1;
        end else if (i_inv_en) begin
            valid[i_wr_index] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            tag_mem[i_wr_index]  <= i_wr_tag;
            data_mem[i_wr_index] <= i_wr_line;
        end
    end

    // registered read
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid[i_rd_index];
        end
    end

    always_ff @(posedge clk) begin
        tag_q  <= tag_mem[i_rd_index];
        o_line <= data_mem[i_rd_index];
    end

    // compare against the tag the controller holds this cycle
    assign o_hit = valid_q && (tag_q == i_cmp_tag);

    // refill and cache operation never share a cycle
    a_no_wr_and_inv: assert property (@(posedge clk) disable iff (!rstn)
        !(i_wr_en && i_inv_en));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the icache testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
    verilator --binary --assert --timescale 1ns/10ps --top-module tb_icache \
        -f filelist.f -o sim_icache &&
    ./obj_dir/sim_icache ||
    { echo "icache simulation failed" >&2; exit 1; }

// ==== src/icache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "icache_macros.svh"

module icache_top import icache_pkg::*; (
    input  wire                        clk,
    input  wire                        rstn,
    // fetch and cache operation
    input  wire                        i_req,
    input  wire [31:0]                 i_addr,
    input  wire                        i_cacop,
    input  wire [1:0]                  i_cacop_code,
    output wire                        o_ready,
    output wire                        o_resp_valid,
    output wire [31:0]                 o_resp_pc,
    output wire [`ICACHE_FETCH_W-1:0]  o_resp_data,
    output wire                        o_resp_adef,
    output wire                        o_cacop_done,
    // line refill
    output wire                        o_mem_req,
    output wire [31:0]                 o_mem_addr,
    input  wire                        i_mem_valid,
    input  wire [`ICACHE_LINE_W-1:0]   i_mem_line
);

    wire [`ICACHE_INDEX_W-1:0] rd_index;
    wire [`ICACHE_TAG_W-1:0]   cmp_tag;
    wire [`ICACHE_INDEX_W-1:0] wr_index;
    wire [`ICACHE_TAG_W-1:0]   wr_tag;
    wire icache_line_u         wr_line;
    wire                       wr_en0;
    wire                       wr_en1;
    wire                       inv_en0;
    wire                       inv_en1;
    wire                       hit0;
    wire                       hit1;
    wire icache_line_u         line0;
    wire icache_line_u         line1;

    // both ways see the same index, tag and line
    icache_way u_way0 (
        .clk        (clk),
        .rstn       (rstn),
        .i_rd_index (rd_index),
        .i_cmp_tag  (cmp_tag),
        .i_wr_en    (wr_en0),
        .i_wr_index (wr_index),
        .i_wr_tag   (wr_tag),
        .i_wr_line  (wr_line),
        .i_inv_en   (inv_en0),
        .o_hit      (hit0),
        .o_line     (line0)
    );

    icache_way u_way1 (
        .clk        (clk),
        .rstn       (rstn),
        .i_rd_index (rd_index),
        .i_cmp_tag  (cmp_tag),
        .i_wr_en    (wr_en1),
        .i_wr_index (wr_index),
        .i_wr_tag   (wr_tag),
        .i_wr_line  (wr_line),
        .i_inv_en   (inv_en1),
        .o_hit      (hit1),
        .o_line     (line1)
    );

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .i_req        (i_req),
        .i_addr       (i_addr),
        .o_ready      (o_ready),
        .o_resp_valid (o_resp_valid),
        .o_resp_pc    (o_resp_pc),
        .o_resp_data  (o_resp_data),
        .o_resp_adef  (o_resp_adef),
        .i_cacop      (i_cacop),
        .i_cacop_code (i_cacop_code),
        .o_cacop_done (o_cacop_done),
        .o_mem_req    (o_mem_req),
        .o_mem_addr   (o_mem_addr),
        .i_mem_valid  (i_mem_valid),
        .i_mem_line   (i_mem_line),
        .o_rd_index   (rd_index),
        .o_cmp_tag    (cmp_tag),
        .o_wr_index   (wr_index),
        .o_wr_tag     (wr_tag),
        .o_wr_line    (wr_line),
        .o_wr_en0     (wr_en0),
        .o_wr_en1     (wr_en1),
        .o_inv_en0    (inv_en0),
        .o_inv_en1    (inv_en1),
        .i_hit0       (hit0),
        .i_hit1       (hit1),
        .i_line0      (line0),
        .i_line1      (line1)
    );

endmodule

`default_nettype wire

// ==== verif/icache_patterns.txt ====
# columns: kind (R fetch, I index invalidate, H hit invalidate), hex address, miss flag
# the miss flag is read for R only, I and H carry 0
# set 4: cold miss, then back-to-back hits
R 00001100 1
R 00001108 0
R 0000113c 0
R 00001110 0
# second and third tag in set 4
R 00002100 1
R 00001120 0
R 00003100 1
R 00001104 0
R 00002100 1
R 00003100 1
R 00002104 0
R 00001100 1
# set 5: three tags, then the first two again
R 00010140 1
R 00020140 1
R 00030140 1
R 00010140 1
R 00020140 1
R 00010148 0
R 00020150 0
# set 0 with hits over several pairs
R 00000000 1
R 00000008 0
R 00000010 0
R 00000038 0
# misaligned fetches
R 00001102 0
R 0000000d 0
R 00000003 0
# index invalidate of way 0 in set 4
I 00000100 0
R 00002100 0
R 00001100 1
R 00002108 0
# hit invalidate of the line in way 1
H 00002100 0
R 00001100 0
R 00002100 1
# hit invalidate that misses
H 00007100 0
R 00001100 0
R 00002100 0
# index invalidate of way 1 in set 5
I 00000141 0
R 00020140 0
R 00010140 1

// ==== verif/tb_icache.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "icache_macros.svh"

module tb_icache import icache_pkg::*; ();

    logic         clk = 1'b0;
    logic         rstn;
    logic         i_req;
    logic [31:0]  i_addr;
    logic         i_cacop;
    logic [1:0]   i_cacop_code;
    logic         i_mem_valid = 1'b0;
    icache_line_u mem_line = '0;

    wire                       o_ready;
    wire                       o_resp_valid;
    wire [31:0]                o_resp_pc;
    wire [`ICACHE_FETCH_W-1:0] o_resp_data;
    wire                       o_resp_adef;
    wire                       o_cacop_done;
    wire                       o_mem_req;
    wire [31:0]                o_mem_addr;

    logic [7:0]  pat_kind [$];
    logic [31:0] pat_addr [$];
    logic        pat_miss [$];
    int          fetch_count = 0;
    int          miss_count = 0;
    int          resp_count = 0;
    int          cycle_count = 0;
    int          timeout_limit = 0;

    // memory model state
    logic [31:0] lcg_state = 32'h9a5e_fe25;
    logic [31:0] mem_base = '0;
    int          mem_wait = 0;
    int          mem_req_count = 0;

    always #10 clk = ~clk;

    icache_top i_dut (
        .clk          (clk),
        .rstn         (rstn),
        .i_req        (i_req),
        .i_addr       (i_addr),
        .i_cacop      (i_cacop),
        .i_cacop_code (i_cacop_code),
        .o_ready      (o_ready),
        .o_resp_valid (o_resp_valid),
        .o_resp_pc    (o_resp_pc),
        .o_resp_data  (o_resp_data),
        .o_resp_adef  (o_resp_adef),
        .o_cacop_done (o_cacop_done),
        .o_mem_req    (o_mem_req),
        .o_mem_addr   (o_mem_addr),
        .i_mem_valid  (i_mem_valid),
        .i_mem_line   (mem_line)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // every memory word is its own byte address xor a fixed mask
    function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
        return byte_addr ^ 32'h5a5a_0000;
    endfunction

    // lower address in the low half
    function automatic logic [63:0] expected_pair(input logic [31:0] addr);
        logic [31:0] base;
        base = {addr[31:3], 3'b000};
        return {mem_word(base + 32'd4), mem_word(base)};
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("ERROR at %0t: %s", $time, what);
            $display("Test FAILED");
            $fatal(1, "%s", what);
        end
    endtask

    task automatic read_patterns();
        int          fd;
        int          fields;
        int          miss;
        string       line;
        logic [31:0] addr;
        logic [7:0]  kind;
        fd = $fopen("verif/icache_patterns.txt", "r");
        check_true(fd != 0, "cannot open the pattern file");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                kind = line[0];
                fields = $sscanf(line.substr(1, line.len() - 1), "%h %d", addr, miss);
                check_true(fields == 2, "malformed line in the pattern file");
                check_true(kind == "R" || kind == "I" || kind == "H",
                           "unknown operation kind in the pattern file");
                pat_kind.push_back(kind);
                pat_addr.push_back(addr);
                pat_miss.push_back(kind == "R" && miss != 0);
                if (kind == "R") begin
                    fetch_count++;
                end
                if (kind == "R" && miss != 0) begin
                    miss_count++;
                end
            end
        end
        $fclose(fd);
        check_true(pat_kind.size() > 0, "the pattern file holds no operations");
    endtask

    task automatic issue(input int idx);
        i_addr = pat_addr[idx];
        if (pat_kind[idx] == "R") begin
            i_req = 1'b1;
        end else begin
            i_cacop = 1'b1;
            i_cacop_code = (pat_kind[idx] == "I") ? `ICACHE_OP_IDX_INV : `ICACHE_OP_HIT_INV;
        end
    endtask

    // called one cycle after the request strobe
    task automatic check_fetch(input int idx);
        logic [31:0] addr;
        logic        fault;
        int          waited;
        int          mem_reqs;
        addr = pat_addr[idx];
        fault = (addr[1:0] != 2'b00);
        waited = 0;
        mem_reqs = 0;
        while (!o_resp_valid) begin
            if (o_mem_req) begin
                mem_reqs++;
                check_value("o_mem_addr",
                            64'(addr & ~32'(`ICACHE_LINE_W / 8 - 1)),
                            64'(o_mem_addr));
            end
            @(negedge clk);
            waited++;
        end
        check_value("o_resp_pc", 64'(addr), 64'(o_resp_pc));
        check_value("o_resp_adef", 64'(fault), 64'(o_resp_adef));
        if (fault) begin
            check_value("o_resp_data", {`ICACHE_NOP, `ICACHE_NOP}, o_resp_data);
        end else begin
            check_value("o_resp_data", expected_pair(addr), o_resp_data);
        end
        check_value("miss flag (o_mem_req seen)", 64'(pat_miss[idx]), 64'(mem_reqs != 0));
        check_true(mem_reqs <= 1, "more than one memory request for a single fetch");
        if (!pat_miss[idx]) begin
            check_true(waited == 0, "response did not come one cycle after the request");
            check_value("o_ready", 64'(1'b1), 64'(o_ready));
        end
    endtask

    task automatic check_cacop();
        check_value("o_cacop_done", 64'(1'b1), 64'(o_cacop_done));
        check_value("o_ready", 64'(1'b0), 64'(o_ready));
        check_value("o_resp_valid", 64'(1'b0), 64'(o_resp_valid));
    endtask

    // every response pulse of the DUT
    always @(negedge clk) begin
        if (o_resp_valid) begin
            resp_count++;
        end
    end

    // line memory with a latency of 1 to 8 cycles per request
    always @(negedge clk) begin
        i_mem_valid = 1'b0;
        if (mem_wait != 0) begin
            mem_wait = mem_wait - 1;
            if (mem_wait == 0) begin
                for (int w = 0; w < `ICACHE_LINE_W / 32; w++) begin
                    mem_line.flat[w*32 +: 32] = mem_word(mem_base + 32'(w * 4));
                end
                i_mem_valid = 1'b1;
            end
        end
        if (o_mem_req) begin
            mem_req_count++;
            lcg_state = lcg_next(lcg_state);
            mem_wait = 1 + int'(lcg_state[18:16]);
            mem_base = o_mem_addr;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
            $display("ERROR: run did not finish within %0d cycles", timeout_limit);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rstn = 1'b0;
        i_req = 1'b0;
        i_addr = '0;
        i_cacop = 1'b0;
        i_cacop_code = '0;
        read_patterns();
        timeout_limit = pat_kind.size() * 16 + 50;
        repeat (5) @(negedge clk);
        check_value("o_ready", 64'(1'b1), 64'(o_ready));
        check_value("o_resp_valid", 64'(1'b0), 64'(o_resp_valid));
        check_value("o_mem_req", 64'(1'b0), 64'(o_mem_req));
        check_value("o_cacop_done", 64'(1'b0), 64'(o_cacop_done));
        rstn = 1'b1;
        @(negedge clk);
        for (int i = 0; i < pat_kind.size(); i++) begin
            while (!o_ready) begin
                @(negedge clk);
            end
            issue(i);
            @(negedge clk);
            i_req = 1'b0;
            i_cacop = 1'b0;
            if (pat_kind[i] == "R") begin
                check_fetch(i);
            end else begin
                check_cacop();
            end
        end
        // stray requests after a hit would show up here
        repeat (4) @(negedge clk);
        @(posedge clk);
        check_true(resp_count == fetch_count, "number of fetch responses is wrong");
        check_true(mem_req_count == miss_count, "memory requests do not match the misses");
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
